/* test/dio_golden.txt */
# B base | F byte_count abort_bits bytes (hex, abort_bits > 0 deselects mid-byte after them)
# W addr data = expected ram write of the frame | E downloading index = state after the frame
B 0A0000
F 2 0 53 01
E 1 00
F 4 0 54 11 22 33
W 0A0000 11
W 0A0001 22
W 0A0002 33
E 1 00
F 3 0 54 44 55
W 0A0003 44
W 0A0004 55
E 1 00
F 2 0 55 2B
E 1 0B
F 2 0 53 00
E 0 0B
F 3 0 7A 54 01
E 0 0B
F 2 0 53 01
E 1 0B
F 3 5 54 A5 5A
W 0A0000 A5
W 0A0001 5A
E 1 0B
F 2 0 55 F3
E 1 13
F 1 3 54
E 1 13
F 2 0 53 00
E 0 13
F 2 0 54 C3
W 0A0002 C3
E 0 13

/* tb.f */
src/dio_pkg.sv
src/spi_frame_if.sv
src/spi_cmd_decoder.sv
src/download_executor.sv
src/ram_write_port.sv
src/data_io.sv
test/dio_checker.sv
test/tb_data_io.sv

/* Bender.yml */
package:
  name: data_io

sources:
  - src/dio_pkg.sv
  - src/spi_frame_if.sv
  - src/spi_cmd_decoder.sv
  - src/download_executor.sv
  - src/ram_write_port.sv
  - src/data_io.sv
  - target: test
    files:
      - test/dio_checker.sv
      - test/tb_data_io.sv

/* test/tb_data_io.sv */
// testbench top, replays the golden frame file into data_io over spi and feeds the checker
`timescale 1ns/1ns

module tb_data_io;

	// has to agree with the B line of the golden file
	localparam dio_pkg::addr_t GOLDEN_BASE = 25'h0A0000;
	localparam GOLDEN_FILE = "test/dio_golden.txt";

	// inter-frame gap in clk cycles, the minimum lets the executor settle
	localparam int MIN_GAP = 8;
	localparam int MAX_GAP = 20;

	logic clk;
	logic ss;
	logic sck;
	logic sdi;
	logic spi_sel;
	logic downloading;
	dio_pkg::file_index_t index;
	logic wr;
	dio_pkg::addr_t addr;
	dio_pkg::byte_t data;

	// current frame from the golden file
	dio_pkg::byte_t frame_bytes [8];
	int frame_len;
	int frame_abort;

	// sck half period in clk cycles, picked per frame
	int half_cycles;

	int cycle_count = 0;
	int cycle_limit = 0;

	data_io #(
		.BASE_ADDR (GOLDEN_BASE)
	) DUT (
		.clk         (clk),
		.ss          (ss),
		.sck         (sck),
		.sdi         (sdi),
		.spi_sel     (spi_sel),
		.downloading (downloading),
		.index       (index),
		.wr          (wr),
		.addr        (addr),
		.data        (data)
	);

	dio_checker chk (
		.clk         (clk),
		.ss          (ss),
		.wr          (wr),
		.addr        (addr),
		.data        (data),
		.downloading (downloading),
		.index       (index)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// cycle limit is zero until the golden file has been sized
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			chk.flag_failure("run did not finish within the cycle limit");
			chk.print_counts();
			$display("TEST FAILED");
			$finish;
		end
	end

	// ****************************************
	// spi driver, all pin changes on falling clk
	// ****************************************

	task automatic wait_falls(input int n);
		repeat (n) @(negedge clk);
	endtask

	// mode 0, data set while sck is low, sampled on the rising edge
	task automatic send_bit(input logic b);
		sdi = b;
		wait_falls(half_cycles);
		sck = 1'b1;
		wait_falls(half_cycles);
		sck = 1'b0;
	endtask

	task automatic send_frame();
		spi_sel = 1'b0;
		wait_falls(half_cycles);
		for (int i = 0; i < frame_len; i++) begin
			// msb first
			for (int j = 7; j >= 0; j--) begin
				send_bit(frame_bytes[i][j]);
			end
		end
		// partial byte, thrown away when spi_sel rises
		for (int k = 0; k < frame_abort; k++) begin
			send_bit(1'($urandom % 2));
		end
		wait_falls(half_cycles);
		spi_sel = 1'b1;
	endtask

	// the queued writes of this frame are the done condition
	task automatic drain_writes();
		int waited;
		waited = 0;
		while (chk.pending_writes() > 0 && waited < 64) begin
			@(negedge clk);
			waited++;
		end
		if (chk.pending_writes() > 0) begin
			chk.flag_failure("expected RAM write did not appear after its frame");
		end
	endtask

	task automatic run_frame();
		half_cycles = 2 + int'($urandom % 3);
		send_frame();
		drain_writes();
		wait_falls(MIN_GAP + int'($urandom % (MAX_GAP - MIN_GAP + 1)));
	endtask

	// ****************************************
	// main sequence
	// ****************************************

	initial begin
		int fd;
		int got;
		int frames;
		int bits;
		int seed_ret;
		string line;
		dio_pkg::addr_t base_in;
		dio_pkg::addr_t w_addr;
		dio_pkg::byte_t w_data;
		logic e_dl;
		dio_pkg::file_index_t e_idx;

		ss = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		spi_sel = 1'b1;
		half_cycles = 2;
		seed_ret = $urandom(32'h63992f59);

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			chk.flag_failure("cannot open the golden file");
		end else begin
			// first pass only sizes the run for the cycle limit
			frames = 0;
			bits = 0;
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if (got > 0 && line[0] == "F") begin
					got = $sscanf(line, "F %d %d", frame_len, frame_abort);
					frames++;
					bits += frame_len * 8 + frame_abort;
				end
			end
			$fclose(fd);
			cycle_limit = bits * 8 + frames * (MAX_GAP + 80) + 200;

			repeat (3) @(posedge clk);
			@(negedge clk);
			ss = 1'b0;
			chk.check_reset_state();

			// second pass, W lines queue writes, the E line sends the frame
			fd = $fopen(GOLDEN_FILE, "r");
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if (got > 0) begin
					case (line[0])
						"B": begin
							got = $sscanf(line, "B %h", base_in);
							if (base_in !== GOLDEN_BASE) begin
								chk.flag_failure("golden base address differs from the DUT base");
							end
						end
						"F": begin
							got = $sscanf(line, "F %d %d %h %h %h %h %h %h %h %h",
								frame_len, frame_abort, frame_bytes[0], frame_bytes[1],
								frame_bytes[2], frame_bytes[3], frame_bytes[4],
								frame_bytes[5], frame_bytes[6], frame_bytes[7]);
						end
						"W": begin
							got = $sscanf(line, "W %h %h", w_addr, w_data);
							chk.push_write(w_addr, w_data);
						end
						"E": begin
							got = $sscanf(line, "E %h %h", e_dl, e_idx);
							run_frame();
							chk.compare_state(e_dl, e_idx);
						end
						default: begin
							// comment or blank line
						end
					endcase
				end
			end
			$fclose(fd);
			chk.report_leftover();
		end

		chk.print_counts();
		if (chk.error_total() == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* test/dio_checker.sv */
// checker for the data_io testbench, compares ram writes and download state with queued expectations
`timescale 1ns/1ns

module dio_checker (
	input logic clk,
	input logic ss,
	input logic wr,
	input dio_pkg::addr_t addr,
	input dio_pkg::byte_t data,
	input logic downloading,
	input dio_pkg::file_index_t index
);

	// expected writes in the order the wr pulses must show them
	dio_pkg::addr_t exp_addr [$];
	dio_pkg::byte_t exp_data [$];

	int mismatch_count = 0;
	int failure_count = 0;

	// wr seen at the previous rising edge
	logic wr_prev = 1'b0;

	task automatic push_write(input dio_pkg::addr_t a, input dio_pkg::byte_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	function automatic int pending_writes();
		return exp_addr.size();
	endfunction

	function automatic int error_total();
		return mismatch_count + failure_count;
	endfunction

	task automatic flag_failure(input string msg);
		failure_count++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	// ****************************************
	// ram write watch
	// ****************************************

	// wr moves on the falling edge, so the rising edge sees it settled
	always @(posedge clk) begin
		if (ss) begin
			wr_prev <= 1'b0;
		end else begin
			wr_prev <= wr;
			if (wr && wr_prev) begin
				flag_failure("wr stayed high for two clk cycles");
			end else if (wr && exp_addr.size() == 0) begin
				flag_failure("RAM write appeared with no expected write left");
			end else if (wr) begin
				compare_value("addr", 32'(exp_addr.pop_front()), 32'(addr));
				compare_value("data", 32'(exp_data.pop_front()), 32'(data));
			end
		end
	end

	// ****************************************
	// state checks, called by the testbench
	// ****************************************

	task automatic check_reset_state();
		compare_value("wr", 32'(1'b0), 32'(wr));
		compare_value("downloading", 32'(1'b0), 32'(downloading));
		compare_value("index", 32'(5'd0), 32'(index));
		compare_value("addr", 32'(0), 32'(addr));
		compare_value("data", 32'(0), 32'(data));
	endtask

	task automatic compare_state(input logic exp_dl, input dio_pkg::file_index_t exp_idx);
		compare_value("downloading", 32'(exp_dl), 32'(downloading));
		compare_value("index", 32'(exp_idx), 32'(index));
	endtask

	task automatic report_leftover();
		if (exp_addr.size() > 0) begin
			flag_failure($sformatf("%0d expected RAM writes never appeared", exp_addr.size()));
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
	endtask

endmodule

/* src/data_io.sv */
// top level of the spi file-download controller, connects decode, execute and ram write stages
`timescale 1ns/1ns

module data_io #(
	// first ram address of a download, default is sideways rom slot e
	parameter dio_pkg::addr_t BASE_ADDR = 25'h68000
) (
	input  logic clk,
	input  logic ss,

	// io controller spi pins
	input  logic sck,
	input  logic sdi,
	input  logic spi_sel,

	// download status
	output logic downloading,
	output dio_pkg::file_index_t index,

	// external ram
	output logic wr,
	output dio_pkg::addr_t addr,
	output dio_pkg::byte_t data
);

	// ****************************************
	// stage links
	// ****************************************

	// decoded bytes, decoder to executor
	spi_frame_if frame_bus ();

	// write requests, executor to write port
	logic req;
	dio_pkg::addr_t req_addr;
	dio_pkg::byte_t req_data;

	// ****************************************
	// stages
	// ****************************************

	spi_cmd_decoder u_decoder (
		.clk     (clk),
		.ss      (ss),
		.sck     (sck),
		.sdi     (sdi),
		.spi_sel (spi_sel),
		.frame   (frame_bus.decoder)
	);

	download_executor #(
		.BASE_ADDR (BASE_ADDR)
	) u_executor (
		.clk         (clk),
		.ss          (ss),
		.frame       (frame_bus.executor),
		.downloading (downloading),
		.index       (index),
		.req         (req),
		.req_addr    (req_addr),
		.req_data    (req_data)
	);

	ram_write_port u_write_port (
		.clk      (clk),
		.ss       (ss),
		.req      (req),
		.req_addr (req_addr),
		.req_data (req_data),
		.wr       (wr),
		.addr     (addr),
		.data     (data)
	);

endmodule

/* src/ram_write_port.sv */
// ram write port, turns a write request into a one-clk write strobe launched on the falling edge
`timescale 1ns/1ns

module ram_write_port (
	input  logic clk,
	input  logic ss,
	input  logic req,
	input  dio_pkg::addr_t req_addr,
	input  dio_pkg::byte_t req_data,
	output logic wr,
	output dio_pkg::addr_t addr,
	output dio_pkg::byte_t data
);

	// request seen, write not yet completed
	logic pending;

	// ****************************************
	// request capture, rising edge
	// ****************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			pending <= 1'b0;
		end else if (req) begin
			pending <= 1'b1;
		end else if (wr) begin
			// strobe is out, this edge is mid-write
			pending <= 1'b0;
		end
	end

	// ****************************************
	// ram side, falling edge
	// ****************************************

	// address and data change half a clk before the ram's rising edge
	// wr drops again on the following falling edge
	always_ff @(negedge clk or posedge ss) begin
		if (ss) begin
			wr <= 1'b0;
			addr <= '0;
			data <= 8'h00;
		end else begin
			wr <= pending;
			if (pending) begin
				addr <= req_addr;
				data <= req_data;
			end
		end
	end

endmodule

/* src/download_executor.sv */
// download executor, acts on decoded payload bytes and produces ram write requests
`timescale 1ns/1ns

module download_executor #(
	// first ram address of a download
	parameter dio_pkg::addr_t BASE_ADDR = 25'h68000
) (
	input  logic clk,
	input  logic ss,
	spi_frame_if.executor frame,
	output logic downloading,
	output dio_pkg::file_index_t index,
	output logic req,
	output dio_pkg::addr_t req_addr,
	output dio_pkg::byte_t req_data
);

	// counter pre-increments, so it sits one below the base
	localparam dio_pkg::addr_t START_ADDR = BASE_ADDR - dio_pkg::addr_t'(1);

	dio_pkg::dl_state_t dl_state;

	// address of the most recent write
	dio_pkg::addr_t addr_cnt;

	// a payload byte to act on this cycle
	logic byte_take;

	// a data byte to be written
	logic data_take;

	assign byte_take = frame.byte_strobe && frame.frame_active;
	assign data_take = byte_take && (frame.cmd == dio_pkg::CMD_FILE_TX_DAT);

	// ****************************************
	// command dispatch
	// ****************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			dl_state <= dio_pkg::dl_idle;
			addr_cnt <= START_ADDR;
			index <= 5'd0;
			req <= 1'b0;
		end else begin
			// req is a single pulse
			req <= 1'b0;
			if (byte_take) begin
				case (frame.cmd)
					dio_pkg::CMD_FILE_TX: begin
						// bit 0 set starts a download, cleared ends it
						if (frame.payload[0]) begin
							dl_state <= dio_pkg::dl_active;
							addr_cnt <= START_ADDR;
						end else begin
							dl_state <= dio_pkg::dl_idle;
						end
					end
					dio_pkg::CMD_FILE_TX_DAT: begin
						// written whether or not a download is active
						addr_cnt <= addr_cnt + dio_pkg::addr_t'(1);
						req <= 1'b1;
					end
					dio_pkg::CMD_FILE_INDEX: begin
						index <= frame.payload[4:0];
					end
					default: begin
						// unknown command, payload dropped
					end
				endcase
			end
		end
	end

	// ****************************************
	// write request payload
	// ****************************************

	// held from req until the next data byte, a start frame
	// reloading addr_cnt does not disturb it
	always_ff @(posedge clk) begin
		if (data_take) begin
			req_addr <= addr_cnt + dio_pkg::addr_t'(1);
			req_data <= frame.payload;
		end
	end

	assign downloading = (dl_state == dio_pkg::dl_active);

endmodule

/* src/spi_cmd_decoder.sv */
// spi frame decoder, samples the io controller pins in the clk domain and splits frames into bytes
`timescale 1ns/1ns

module spi_cmd_decoder (
	input  logic clk,
	input  logic ss,
	input  logic sck,
	input  logic sdi,
	input  logic spi_sel,
	spi_frame_if.decoder frame
);

	// two-flop synchronizers, index 1 is the safe stage
	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic [1:0] sel_sync;

	// previous synchronized sck for edge detection
	logic sck_prev;

	logic sck_rise;
	logic sdi_s;
	logic sel_s;

	// bit position inside the current byte
	logic [2:0] bit_cnt;

	// command byte or payload bytes
	dio_pkg::frame_phase_t phase;

	// first seven bits of a byte, the eighth is taken live
	logic [6:0] sbuf;

	dio_pkg::byte_t cmd_q;

	// ****************************************
	// pin synchronization
	// ****************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			sck_sync <= 2'b00;
			sdi_sync <= 2'b00;
			// chip select idles high, i.e. deselected
			sel_sync <= 2'b11;
			sck_prev <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			sdi_sync <= {sdi_sync[0], sdi};
			sel_sync <= {sel_sync[0], spi_sel};
			sck_prev <= sck_sync[1];
		end
	end

	assign sdi_s = sdi_sync[1];
	assign sel_s = sel_sync[1];

	// sdi went through the same two stages, so it lines up with this edge
	assign sck_rise = sck_sync[1] & ~sck_prev;

	// ****************************************
	// bit counter and frame phase
	// ****************************************

	// {phase, bit_cnt} walks 0-7 for the command, then 8-15 over and over
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			bit_cnt <= 3'd0;
			phase <= dio_pkg::phase_cmd;
			cmd_q <= 8'h00;
		end else if (sel_s) begin
			// deselect aborts the frame, partial byte is lost
			// cmd_q stays as it was
			bit_cnt <= 3'd0;
			phase <= dio_pkg::phase_cmd;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				// command byte complete
				if (phase == dio_pkg::phase_cmd) begin
					cmd_q <= {sbuf, sdi_s};
				end
				phase <= dio_pkg::phase_data;
			end
		end
	end

	// shift register, last bit of a byte is not shifted in
	always_ff @(posedge clk) begin
		if (sck_rise && !sel_s && bit_cnt != 3'd7) begin
			sbuf <= {sbuf[5:0], sdi_s};
		end
	end

	// ****************************************
	// frame bus
	// ****************************************

	// strobe on the very cycle the eighth payload bit is sampled
	assign frame.byte_strobe = sck_rise && !sel_s &&
		(phase == dio_pkg::phase_data) && (bit_cnt == 3'd7);

	assign frame.payload = {sbuf, sdi_s};
	assign frame.cmd = cmd_q;
	assign frame.frame_active = !sel_s && (phase == dio_pkg::phase_data);

endmodule

/* src/spi_frame_if.sv */
// decoded spi frame bus, driven by the command decoder and read by the download executor
`timescale 1ns/1ns

interface spi_frame_if;

	// one clk pulse per completed payload byte
	logic byte_strobe;

	// the completed byte, only meaningful while byte_strobe is high
	dio_pkg::byte_t payload;

	// command byte of the current frame
	// held until the next frame delivers its own
	dio_pkg::byte_t cmd;

	// frame selected and past its command byte
	logic frame_active;

	// decoder side drives everything
	modport decoder (
		output byte_strobe, payload, cmd, frame_active
	);

	// executor only looks
	modport executor (
		input byte_strobe, payload, cmd, frame_active
	);

endinterface

/* src/dio_pkg.sv */
// shared widths, types and command codes of the file-download controller, referenced by scope
package dio_pkg;

	// ****************************************
	// widths
	// ****************************************

	// ram byte address width, covers the 32 MB sdram of the board
	parameter int ADDR_W = 25;

	// one byte as it arrives over spi
	typedef logic [7:0] byte_t;

	// ram byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// menu index of the file being downloaded
	typedef logic [4:0] file_index_t;

	// ****************************************
	// io controller commands
	// ****************************************

	// start or end a download, payload bit 0 selects which
	parameter byte_t CMD_FILE_TX = 8'h53;

	// every payload byte goes to the next ram address
	parameter byte_t CMD_FILE_TX_DAT = 8'h54;

	// payload bits 4..0 give the menu index
	parameter byte_t CMD_FILE_INDEX = 8'h55;

	// ****************************************
	// state machines
	// ****************************************

	// decoder position inside a frame
	typedef enum logic {
		phase_cmd,
		phase_data
	} frame_phase_t;

	// download status kept by the executor
	typedef enum logic {
		dl_idle,
		dl_active
	} dl_state_t;

endpackage
